/* mips_alu.sv */
// integer alu
// add, subtract, bitwise logic, signed and unsigned compare and
// shifts of b by the instruction shift amount
`timescale 1ns/100ps

module mips_alu import mips_pkg::*; (
   input  alu_op_e    op,
   input  word_t      a,
   input  word_t      b,
   input  logic [4:0] shamt,
   output word_t      result
);

   always_comb begin
      case (op)
         ALU_ADD:  result = a + b;
         ALU_SUB:  result = a - b;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         ALU_NOR:  result = ~(a | b);
         // compares return 0 or 1
         ALU_SLT:  result = word_t'($signed(a) < $signed(b));
         ALU_SLTU: result = word_t'(a < b);
         // shifts act on the rt operand
         ALU_SLL:  result = b << shamt;
         ALU_SRL:  result = b >> shamt;
         ALU_SRA:  result = $signed(b) >>> shamt;
         default:  result = '0;
      endcase
   end

endmodule

/* mips_bus_arbiter.sv */
// shared memory bus arbiter
// the load/store unit always wins; fetch gets the bus only in a
// cycle with no load or store, and then reads with we low
`timescale 1ns/100ps

module mips_bus_arbiter import mips_pkg::*; (
   input  logic     fetch_req,
   input  addr_t    fetch_addr,
   input  logic     lsu_req,
   input  mem_req_t lsu_bus,
   output logic     fetch_gnt,
   output mem_req_t mem_req
);

   assign fetch_gnt = fetch_req && !lsu_req;

   always_comb begin
      if (lsu_req) begin
         mem_req = lsu_bus;
      end else begin
         // instruction read
         mem_req.addr  = fetch_addr;
         mem_req.wdata = '0;
         mem_req.be    = '0;
         mem_req.we    = 1'b0;
      end
   end

endmodule

/* mips_chk.sv */
// bus and halt rule checker
// bound to the core; watches the shared bus write strobe, the byte
// lanes and the sticky halt flag
`timescale 1ns/100ps

module mips_chk import mips_pkg::*; (
   input logic     clk,
   input logic     rst_b,
   input mem_req_t mem_req,
   input logic     halted
);

   // every write enables at least one lane
   a_write_lanes: assert property (@(posedge clk) disable iff (!rst_b)
      mem_req.we |-> mem_req.be != '0)
      else $error("bus write with no byte lane enabled");

   // a halted core leaves memory alone
   a_no_write_halted: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> !mem_req.we)
      else $error("bus write while the core is halted");

   // only reset clears halted
   a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
      !$fell(halted))
      else $error("halted dropped without reset");

endmodule

/* mips_core.sv */
// three-stage mips integer core
// fetch, execute (decode, register read, alu) and writeback (memory
// access, register write); one shared bus for instructions and data
`timescale 1ns/100ps

module mips_core import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  word_t    mem_rdata,
   output mem_req_t mem_req,
   output logic     halted
);

   // fetch and bus
   logic       fetch_req;
   logic       fetch_gnt;
   addr_t      fetch_addr;
   word_t      instr;
   logic       instr_valid;
   logic       lsu_req;
   mem_req_t   lsu_bus;
   // execute
   ex_ctrl_t   ex_ctrl;
   word_t      ex_imm;
   reg_idx_t   rs_idx;
   reg_idx_t   rt_idx;
   logic [4:0] shamt;
   word_t      rs_data;
   word_t      rt_data;
   word_t      alu_b;
   word_t      alu_result;
   // writeback
   logic       wb_valid;
   ex_ctrl_t   wb_ctrl;
   word_t      wb_result;
   word_t      wb_rt;
   logic       wb_live;
   logic       wb_load;
   logic       wr_en;
   word_t      wr_data;
   word_t      load_data;

   mips_fetch i_mips_fetch (.clk, .rst_b, .halted, .fetch_gnt, .mem_rdata, .fetch_req,
      .fetch_addr, .instr, .instr_valid);

   mips_decode i_mips_decode (.instr, .instr_valid, .ctrl(ex_ctrl), .imm(ex_imm),
      .rs(rs_idx), .rt(rt_idx), .shamt);

   mips_regfile i_mips_regfile (.clk, .rst_b, .rs(rs_idx), .rt(rt_idx), .rs_data,
      .rt_data, .wr_en, .wr_idx(wb_ctrl.dest), .wr_data);

   assign alu_b = ex_ctrl.use_imm ? ex_imm : rt_data;

   mips_alu i_mips_alu (.op(ex_ctrl.alu_op), .a(rs_data), .b(alu_b), .shamt,
      .result(alu_result));

   // execute to writeback register, control part
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_valid <= 1'b0;
         wb_ctrl  <= '0;
      end else begin
         wb_valid <= instr_valid;
         wb_ctrl  <= ex_ctrl;
      end
   end

   // alu result doubles as the load/store byte address
   always_ff @(posedge clk) begin
      wb_result <= alu_result;
      wb_rt     <= rt_data;
   end

   // the slot behind a syscall has no effect once halted
   assign wb_live = wb_valid && !halted;
   assign wb_load = wb_ctrl.mem_op inside {MEM_LW, MEM_LB, MEM_LBU};

   mips_lsu i_mips_lsu (.mem_op(wb_ctrl.mem_op), .addr(wb_result), .store_data(wb_rt),
      .enable(wb_live), .mem_rdata, .lsu_req, .lsu_bus, .load_data);

   mips_bus_arbiter i_mips_bus_arbiter (.fetch_req, .fetch_addr, .lsu_req, .lsu_bus,
      .fetch_gnt, .mem_req);

   assign wr_en   = wb_live && wb_ctrl.reg_we;
   assign wr_data = wb_load ? load_data : wb_result;

   // sticky until reset
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halted <= 1'b0;
      end else if (wb_live && wb_ctrl.syscall) begin
         halted <= 1'b1;
      end
   end

endmodule

/* mips_decode.sv */
// instruction decoder
// maps opcode and funct to alu and memory control, picks the
// destination register and builds the extended immediate
`timescale 1ns/100ps
`include "mips_defs.svh"

module mips_decode import mips_pkg::*; (
   input  word_t      instr,
   input  logic       instr_valid,
   output ex_ctrl_t   ctrl,
   output word_t      imm,
   output reg_idx_t   rs,
   output reg_idx_t   rt,
   output logic [4:0] shamt
);

   logic [5:0] op;
   logic [5:0] funct;
   reg_idx_t   rd;

   // instruction fields
   assign op    = instr[31:26];
   assign rs    = instr[25:21];
   assign rt    = instr[20:16];
   assign rd    = instr[15:11];
   assign shamt = instr[10:6];
   assign funct = instr[5:0];

   // logical immediates zero extend, lui pre-shifts, the rest sign extend
   always_comb begin
      case (op)
         `OP_ANDI, `OP_ORI, `OP_XORI: imm = {16'h0, instr[15:0]};
         `OP_LUI:                     imm = {instr[15:0], 16'h0};
         default:                     imm = {{16{instr[15]}}, instr[15:0]};
      endcase
   end

   always_comb begin
      ctrl = '0;
      if (instr_valid) begin
         // i-type layout, overridden below for r-type
         ctrl.dest    = rt;
         ctrl.use_imm = 1'b1;
         ctrl.reg_we  = 1'b1;
         case (op)
            `OP_RTYPE: begin
               ctrl.dest    = rd;
               ctrl.use_imm = 1'b0;
               case (funct)
                  `FN_ADDU:    ctrl.alu_op = ALU_ADD;
                  `FN_SUBU:    ctrl.alu_op = ALU_SUB;
                  `FN_AND:     ctrl.alu_op = ALU_AND;
                  `FN_OR:      ctrl.alu_op = ALU_OR;
                  `FN_XOR:     ctrl.alu_op = ALU_XOR;
                  `FN_NOR:     ctrl.alu_op = ALU_NOR;
                  `FN_SLT:     ctrl.alu_op = ALU_SLT;
                  `FN_SLTU:    ctrl.alu_op = ALU_SLTU;
                  `FN_SLL:     ctrl.alu_op = ALU_SLL;
                  `FN_SRL:     ctrl.alu_op = ALU_SRL;
                  `FN_SRA:     ctrl.alu_op = ALU_SRA;
                  // no register result, halts in writeback
                  `FN_SYSCALL: begin
                     ctrl.reg_we  = 1'b0;
                     ctrl.syscall = 1'b1;
                  end
                  default:     ctrl = '0;
               endcase
            end
            `OP_ADDIU: ctrl.alu_op = ALU_ADD;
            `OP_SLTI:  ctrl.alu_op = ALU_SLT;
            `OP_ANDI:  ctrl.alu_op = ALU_AND;
            `OP_ORI:   ctrl.alu_op = ALU_OR;
            `OP_XORI:  ctrl.alu_op = ALU_XOR;
            // rs field is zero, so or passes the shifted immediate
            `OP_LUI:   ctrl.alu_op = ALU_OR;
            // loads and stores add base and offset
            `OP_LW:    ctrl.mem_op = MEM_LW;
            `OP_LB:    ctrl.mem_op = MEM_LB;
            `OP_LBU:   ctrl.mem_op = MEM_LBU;
            `OP_SW: begin
               ctrl.mem_op = MEM_SW;
               ctrl.reg_we = 1'b0;
            end
            `OP_SB: begin
               ctrl.mem_op = MEM_SB;
               ctrl.reg_we = 1'b0;
            end
            // unknown opcode runs as a no-op
            default:   ctrl = '0;
         endcase
      end
   end

endmodule

/* mips_defs.svh */
// mips core shared constants
// widths, reset fetch address and the opcode and funct encodings
// of the supported integer subset
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// datapath widths
`define MIPS_WORD_W      32
`define MIPS_ADDR_W      30
`define MIPS_REG_W       5

// byte address of the first instruction
`define MIPS_TEXT_START  32'h0040_0000

// primary opcodes
`define OP_RTYPE         6'h00
`define OP_ADDIU         6'h09
`define OP_SLTI          6'h0a
`define OP_ANDI          6'h0c
`define OP_ORI           6'h0d
`define OP_XORI          6'h0e
`define OP_LUI           6'h0f
`define OP_LB            6'h20
`define OP_LW            6'h23
`define OP_LBU           6'h24
`define OP_SB            6'h28
`define OP_SW            6'h2b

// funct field of r-type words
`define FN_SLL           6'h00
`define FN_SRL           6'h02
`define FN_SRA           6'h03
`define FN_SYSCALL       6'h0c
`define FN_ADDU          6'h21
`define FN_SUBU          6'h23
`define FN_AND           6'h24
`define FN_OR            6'h25
`define FN_XOR           6'h26
`define FN_NOR           6'h27
`define FN_SLT           6'h2a
`define FN_SLTU          6'h2b

`endif

/* mips_fetch.sv */
// fetch stage
// holds the word pc and the instruction register; asks for the bus
// every cycle until halt and retries the same pc when not granted
`timescale 1ns/100ps
`include "mips_defs.svh"

module mips_fetch import mips_pkg::*; (
   input  logic  clk,
   input  logic  rst_b,
   input  logic  halted,
   input  logic  fetch_gnt,
   input  word_t mem_rdata,
   output logic  fetch_req,
   output addr_t fetch_addr,
   output word_t instr,
   output logic  instr_valid
);

   addr_t pc;

   assign fetch_req  = !halted;
   assign fetch_addr = pc;

   // pc advances one word per granted fetch
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc          <= addr_t'(`MIPS_TEXT_START >> 2);
         instr_valid <= 1'b0;
      end else if (fetch_gnt) begin
         pc          <= pc + 1'b1;
         instr_valid <= 1'b1;
      end else begin
         // lost the bus, a bubble goes into execute
         instr_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_gnt) begin
         instr <= mem_rdata;
      end
   end

endmodule

/* mips_lsu.sv */
// load/store unit
// builds the bus request of the instruction in writeback with
// byte lanes for sb, and aligns and extends byte loads
`timescale 1ns/100ps

module mips_lsu import mips_pkg::*; (
   input  mem_op_e  mem_op,
   input  word_t    addr,
   input  word_t    store_data,
   input  logic     enable,
   input  word_t    mem_rdata,
   output logic     lsu_req,
   output mem_req_t lsu_bus,
   output word_t    load_data
);

   logic       is_store;
   logic [1:0] lane;
   logic [7:0] rbyte;

   assign lane     = addr[1:0];
   assign is_store = (mem_op == MEM_SW) || (mem_op == MEM_SB);
   assign lsu_req  = enable && (mem_op != MEM_NONE);

   always_comb begin
      lsu_bus.addr  = addr[31:2];
      lsu_bus.wdata = store_data;
      lsu_bus.be    = '0;
      lsu_bus.we    = enable && is_store;
      if (mem_op == MEM_SW) begin
         lsu_bus.be = '1;
      end else if (mem_op == MEM_SB) begin
         // byte on every lane, only the addressed one enabled
         lsu_bus.wdata = {4{store_data[7:0]}};
         lsu_bus.be    = byte_en_t'(1) << lane;
      end
   end

   // lane 0 is the low byte of the word
   assign rbyte = mem_rdata[lane*8 +: 8];

   always_comb begin
      case (mem_op)
         MEM_LB:  load_data = {{24{rbyte[7]}}, rbyte};
         MEM_LBU: load_data = {24'h0, rbyte};
         default: load_data = mem_rdata;
      endcase
   end

endmodule

/* mips_pkg.sv */
// mips core types
// vector types for words, addresses and register numbers, the alu
// and memory operation encodings, and the control and bus structs
`include "mips_defs.svh"

package mips_pkg;

   // plain vectors with a meaning
   typedef logic [`MIPS_WORD_W-1:0]   word_t;
   typedef logic [`MIPS_ADDR_W-1:0]   addr_t;
   typedef logic [`MIPS_REG_W-1:0]    reg_idx_t;
   typedef logic [`MIPS_WORD_W/8-1:0] byte_en_t;

   // alu operation, add is the zero value
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
   } alu_op_e;

   // memory operation of the instruction in writeback
   typedef enum logic [2:0] {
      MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB
   } mem_op_e;

   // per-instruction control carried from execute into writeback
   typedef struct packed {
      alu_op_e  alu_op;
      mem_op_e  mem_op;
      // second alu operand is the extended immediate
      logic     use_imm;
      logic     reg_we;
      reg_idx_t dest;
      logic     syscall;
   } ex_ctrl_t;

   // one request on the shared memory bus
   typedef struct packed {
      addr_t    addr;
      word_t    wdata;
      byte_en_t be;
      logic     we;
   } mem_req_t;

endpackage

/* mips_regfile.sv */
// general purpose register file
// 32 registers, two read ports and one write port; a read of the
// register being written returns the new value in the same cycle
`timescale 1ns/100ps

module mips_regfile import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  reg_idx_t rs,
   input  reg_idx_t rt,
   output word_t    rs_data,
   output word_t    rt_data,
   input  logic     wr_en,
   input  reg_idx_t wr_idx,
   input  word_t    wr_data
);

   word_t regs [32];

   // $zero is never written
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_idx != '0) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // write-through bypass for the instruction in execute
   assign rs_data = (rs == '0) ? '0 : (wr_en && wr_idx == rs) ? wr_data : regs[rs];
   assign rt_data = (rt == '0) ? '0 : (wr_en && wr_idx == rt) ? wr_data : regs[rt];

endmodule

/* mips_tb.sv */
// testbench for the three-stage mips core
// 256-word memory model on the shared bus, an instruction encoder
// and directed tests that run a program up to syscall and then
// compare the data words against values worked out here
`timescale 1ns/100ps
`include "mips_defs.svh"

module mips_tb import mips_pkg::*; ();

   // r-type functions in the order the r-type test stores them
   localparam logic [5:0] R_FUNCTS [11] = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR,
      `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA};

   logic     clk;
   logic     rst_b;
   logic     rst_req;
   logic     halted;
   mem_req_t mem_req;
   word_t    mem_rdata;
   word_t    mem [256];
   byte_en_t be_log [$];
   int       wp;
   integer   seed;
   int       checks;
   int       errors;
   int       timeouts;

   tb_clk_gen i_tb_clk_gen (.rst_req(rst_req), .clk(clk), .rst_b(rst_b));

   mips_core i_mips_core (.clk(clk), .rst_b(rst_b), .mem_rdata(mem_rdata),
      .mem_req(mem_req), .halted(halted));

   bind mips_core mips_chk i_mips_chk (.clk(clk), .rst_b(rst_b), .mem_req(mem_req),
      .halted(halted));

   // memory model indexed by the low 8 word address bits
   assign mem_rdata = mem[mem_req.addr[7:0]];

   // lane writes at the edge with each lane mask logged
   always @(posedge clk) begin
      if (mem_req.we) begin
         for (int l = 0; l < 4; l++) begin
            if (mem_req.be[l]) begin
               mem[mem_req.addr[7:0]][l*8 +: 8] <= mem_req.wdata[l*8 +: 8];
            end
         end
         be_log.push_back(mem_req.be);
      end
   end

   function automatic word_t fill_word(int idx);
      return {~8'(idx), 8'(idx), 8'(idx) ^ 8'h3c, 8'(idx) + 8'h81};
   endfunction

   function automatic word_t enc_r(logic [5:0] fn, reg_idx_t rd, reg_idx_t rs,
                                   reg_idx_t rt, logic [4:0] sh);
      return {`OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t enc_i(logic [5:0] op, reg_idx_t rt, reg_idx_t rs,
                                   logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // r-type result from the instruction set rules
   function automatic word_t expect_rtype(logic [5:0] fn, word_t a, word_t b,
                                          logic [4:0] sh);
      case (fn)
         `FN_ADDU: return a + b;
         `FN_SUBU: return a - b;
         `FN_AND:  return a & b;
         `FN_OR:   return a | b;
         `FN_XOR:  return a ^ b;
         `FN_NOR:  return ~(a | b);
         `FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         `FN_SLTU: return (a < b) ? 32'd1 : 32'd0;
         `FN_SLL:  return b << sh;
         `FN_SRL:  return b >> sh;
         default:  return $signed(b) >>> sh;
      endcase
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %08h expected %08h", $time, name, got, exp);
      end
   endtask

   task automatic check_be(input string name, input byte_en_t got, input byte_en_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %04b expected %04b", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %08h expected %08h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic fill_mem;
      for (int i = 0; i < 256; i++) begin
         mem[i] = fill_word(i);
      end
   endtask

   task automatic emit(input word_t w);
      mem[wp] = w;
      wp++;
   endtask

   // core goes into reset while memory is reloaded
   task automatic begin_test(input string name);
      $display("running %s", name);
      @(posedge clk);
      #1 rst_req = 1'b1;
      fill_mem;
      be_log.delete();
      wp = 0;
   endtask

   task automatic wait_reset_release;
      int n;
      n = 0;
      while (!rst_b && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (!rst_b) begin
         timeouts++;
         $display("timeout, reset was never released");
      end
   endtask

   task automatic wait_halt;
      int n;
      n = 0;
      while (!halted && n < 500) begin
         @(negedge clk);
         n++;
      end
      if (!halted) begin
         timeouts++;
         $display("timeout, core never reached its syscall");
      end
   endtask

   // reset state is checked before the first fetch edge
   task automatic run_program;
      @(posedge clk);
      #1 rst_req = 1'b0;
      wait_reset_release;
      check_bit("halted after reset", halted, 1'b0);
      check_addr("first mem_req.addr", mem_req.addr, addr_t'(`MIPS_TEXT_START / 4));
      wait_halt;
   endtask

   task automatic test_rtype;
      word_t      a;
      word_t      b;
      logic [4:0] sh;
      begin_test("r-type operations");
      a  = $random(seed);
      b  = $random(seed);
      sh = 5'($random(seed));
      mem[8'h80] = a;
      mem[8'h81] = b;
      emit(enc_i(`OP_LW, 5'd1, 5'd0, 16'h0200));
      emit(enc_i(`OP_LW, 5'd2, 5'd0, 16'h0204));
      for (int i = 0; i < 11; i++) begin
         emit(enc_r(R_FUNCTS[i], 5'd3, 5'd1, 5'd2, sh));
         emit(enc_i(`OP_SW, 5'd3, 5'd0, 16'h0208 + 16'(4 * i)));
      end
      emit(enc_r(`FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program;
      for (int i = 0; i < 11; i++) begin
         check_word($sformatf("mem[%0h] funct %0h", 8'h82 + i, R_FUNCTS[i]),
            mem[8'h82 + i], expect_rtype(R_FUNCTS[i], a, b, sh));
      end
   endtask

   task automatic test_immediates;
      word_t       a;
      word_t       sx;
      word_t       zx;
      word_t       exp [6];
      logic [15:0] imm;
      logic [5:0]  ops [6];
      begin_test("immediate operations");
      a   = $random(seed);
      // bit 15 set tells sign from zero extension apart
      imm = 16'($random(seed)) | 16'h8000;
      sx  = {{16{imm[15]}}, imm};
      zx  = {16'h0, imm};
      mem[8'h80] = a;
      ops = '{`OP_ADDIU, `OP_SLTI, `OP_LUI, `OP_ANDI, `OP_ORI, `OP_XORI};
      exp = '{a + sx, ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0, {imm, 16'h0},
               a & zx, a | zx, a ^ zx};
      emit(enc_i(`OP_LW, 5'd5, 5'd0, 16'h0200));
      for (int i = 0; i < 6; i++) begin
         // lui takes no source register
         emit(enc_i(ops[i], 5'd1, (ops[i] == `OP_LUI) ? 5'd0 : 5'd5, imm));
         emit(enc_i(`OP_SW, 5'd1, 5'd0, 16'h0210 + 16'(4 * i)));
      end
      emit(enc_r(`FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program;
      for (int i = 0; i < 6; i++) begin
         check_word($sformatf("mem[%0h] opcode %0h", 8'h84 + i, ops[i]),
            mem[8'h84 + i], exp[i]);
      end
   endtask

   task automatic test_bytes;
      begin_test("byte stores and loads");
      mem[8'h84] = 32'h1122_3344;
      emit(enc_i(`OP_ORI, 5'd1, 5'd0, 16'h00c7));
      // lane 2 of word 0x84
      emit(enc_i(`OP_SB, 5'd1, 5'd0, 16'h0212));
      emit(enc_i(`OP_LB, 5'd2, 5'd0, 16'h0212));
      emit(enc_i(`OP_LBU, 5'd3, 5'd0, 16'h0212));
      emit(enc_i(`OP_SW, 5'd2, 5'd0, 16'h0220));
      emit(enc_i(`OP_SW, 5'd3, 5'd0, 16'h0224));
      emit(enc_r(`FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program;
      if (be_log.size() == 0) begin
         errors++;
         $display("no bus write was seen for the byte store");
      end else begin
         check_be("sb mem_req.be", be_log[0], 4'b0100);
      end
      check_word("sb target word", mem[8'h84], 32'h11c7_3344);
      check_word("lb result", mem[8'h88], 32'hffff_ffc7);
      check_word("lbu result", mem[8'h89], 32'h0000_00c7);
   endtask

   task automatic test_chain;
      word_t       a;
      word_t       r1;
      word_t       r5;
      logic [15:0] k;
      begin_test("dependent chain and load use");
      a = $random(seed);
      k = 16'($random(seed));
      mem[8'h80] = a;
      emit(enc_i(`OP_ADDIU, 5'd1, 5'd0, k));
      emit(enc_r(`FN_ADDU, 5'd2, 5'd1, 5'd1, 5'd0));
      emit(enc_r(`FN_SUBU, 5'd3, 5'd2, 5'd1, 5'd0));
      emit(enc_r(`FN_XOR, 5'd4, 5'd3, 5'd2, 5'd0));
      emit(enc_r(`FN_SLL, 5'd5, 5'd0, 5'd4, 5'd3));
      // the add reads r6 while the load writes it
      emit(enc_i(`OP_LW, 5'd6, 5'd0, 16'h0200));
      emit(enc_r(`FN_ADDU, 5'd7, 5'd6, 5'd5, 5'd0));
      emit(enc_i(`OP_SW, 5'd7, 5'd0, 16'h0230));
      emit(enc_i(`OP_SW, 5'd5, 5'd0, 16'h0234));
      emit(enc_r(`FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program;
      r1 = {{16{k[15]}}, k};
      // r3 = 2*r1 - r1, r4 = r3 ^ 2*r1
      r5 = (r1 ^ (r1 + r1)) << 3;
      check_word("chain result", mem[8'h8d], r5);
      check_word("load use result", mem[8'h8c], a + r5);
   endtask

   task automatic test_halt;
      begin_test("syscall halt");
      emit(enc_i(`OP_ORI, 5'd1, 5'd0, 16'h1234));
      emit(enc_i(`OP_SW, 5'd1, 5'd0, 16'h0240));
      emit(enc_r(`FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      emit(enc_i(`OP_SW, 5'd1, 5'd0, 16'h0244));
      run_program;
      check_word("store before syscall", mem[8'h90], 32'h0000_1234);
      // the store behind the syscall reaches writeback a cycle after halt
      repeat (8) begin
         @(negedge clk);
         check_bit("halted", halted, 1'b1);
      end
      check_word("store after syscall", mem[8'h91], fill_word(8'h91));
   endtask

   initial begin
      rst_req  = 1'b0;
      seed     = 30;
      checks   = 0;
      errors   = 0;
      timeouts = 0;
      wp       = 0;
      fill_mem;
      test_rtype;
      test_immediates;
      test_bytes;
      test_chain;
      test_halt;
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* run.sh */
#!/bin/sh
# build and run the mips core testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module mips_tb -f src.f \
   -o mips_sim || exit 1
./obj_dir/mips_sim > sim.log 2>&1
cat sim.log
grep -qx "TESTS PASSED" sim.log && echo "simulation ok" || exit 1

/* src.f */
+incdir+.
mips_pkg.sv
mips_alu.sv
mips_decode.sv
mips_regfile.sv
mips_fetch.sv
mips_lsu.sv
mips_bus_arbiter.sv
mips_core.sv
mips_chk.sv
tb_clk_gen.sv
mips_tb.sv

/* tb_clk_gen.sv */
// testbench clock and reset source
// 8 ns clock; rst_b is held low for three rising edges at start
// and again after every rising edge of rst_req
`timescale 1ns/100ps

module tb_clk_gen (
   input  logic rst_req,
   output logic clk,
   output logic rst_b
);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // release 1 ns after the third edge, like any other input
   always begin
      rst_b = 1'b0;
      repeat (3) @(posedge clk);
      #1 rst_b = 1'b1;
      @(posedge rst_req);
   end

endmodule
